// ==== rtl/ooo_pkg.sv ====
package ooo_pkg;

  typedef logic [31:0] word_t;

  typedef logic [4:0] arch_reg_t;

  // tag width at the default DEPTH of 8
  typedef logic [2:0] rob_tag_t;

  typedef enum logic [2:0] {
    op_add,
    op_sub,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_slt
  } alu_op_e;

  // st_drain holds commit for one cycle after an x0 or colliding retire
  typedef enum logic [0:0] {
    st_run,
    st_drain
  } commit_state_e;

endpackage

// ==== rtl/rename_table.sv ====
`timescale 1ns/10ps

module rename_table #(
  parameter int DEPTH = 8,
  localparam int TAG_W = $clog2(DEPTH)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  ooo_pkg::arch_reg_t rs1_i,
  input  ooo_pkg::arch_reg_t rs2_i,
  input  logic               alloc_i,
  input  ooo_pkg::arch_reg_t alloc_rd_i,
  input  logic [TAG_W-1:0]   alloc_tag_i,
  input  logic               clear_i,
  input  ooo_pkg::arch_reg_t clear_rd_i,
  input  logic [TAG_W-1:0]   clear_tag_i,
  output logic               rs1_busy_o,
  output logic [TAG_W-1:0]   rs1_tag_o,
  output logic               rs2_busy_o,
  output logic [TAG_W-1:0]   rs2_tag_o
);

  logic [31:0]      busy_q;
  logic [TAG_W-1:0] tag_q [32];
  logic             alloc_en;
  logic             clear_en;

  // x0 never gets a producer
  assign alloc_en = alloc_i && (alloc_rd_i != '0);

  // only the newest producer may release its register
  assign clear_en = clear_i && busy_q[clear_rd_i] &&
                    (tag_q[clear_rd_i] == clear_tag_i) &&
                    !(alloc_en && (alloc_rd_i == clear_rd_i));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      busy_q <= '0;
    end else begin
      if (clear_en) begin
        busy_q[clear_rd_i] <= 1'b0;
      end
      if (alloc_en) begin
        busy_q[alloc_rd_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_en) begin
      tag_q[alloc_rd_i] <= alloc_tag_i;
    end
  end

  assign rs1_busy_o = busy_q[rs1_i];
  assign rs1_tag_o  = tag_q[rs1_i];
  assign rs2_busy_o = busy_q[rs2_i];
  assign rs2_tag_o  = tag_q[rs2_i];

endmodule

// ==== rtl/arch_regfile.sv ====
`timescale 1ns/10ps

module arch_regfile (
  input  logic               clk,
  input  logic               rst_n,
  input  ooo_pkg::arch_reg_t raddr0_i,
  input  ooo_pkg::arch_reg_t raddr1_i,
  input  logic               we_i,
  input  ooo_pkg::arch_reg_t waddr_i,
  input  ooo_pkg::word_t     wdata_i,
  output ooo_pkg::word_t     rdata0_o,
  output ooo_pkg::word_t     rdata1_o
);

  ooo_pkg::word_t regs_q [32];
  logic           wr_en;

  assign wr_en = we_i && (waddr_i != '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs_q[i] <= '0;
      end
    end else if (wr_en) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // write-through forwarding
  assign rdata0_o = (wr_en && (waddr_i == raddr0_i)) ? wdata_i : regs_q[raddr0_i];
  assign rdata1_o = (wr_en && (waddr_i == raddr1_i)) ? wdata_i : regs_q[raddr1_i];

endmodule

// ==== rtl/reorder_buffer.sv ====
`timescale 1ns/10ps

module reorder_buffer #(
  parameter int DEPTH = 8,
  localparam int TAG_W = $clog2(DEPTH)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               alloc_i,
  input  ooo_pkg::arch_reg_t alloc_rd_i,
  input  logic               cdb_valid_i,
  input  logic [TAG_W-1:0]   cdb_tag_i,
  input  ooo_pkg::word_t     cdb_data_i,
  input  logic [TAG_W-1:0]   src0_tag_i,
  input  logic [TAG_W-1:0]   src1_tag_i,
  input  logic               retire_i,
  output logic [TAG_W-1:0]   alloc_tag_o,
  output logic               src0_done_o,
  output ooo_pkg::word_t     src0_data_o,
  output logic               src1_done_o,
  output ooo_pkg::word_t     src1_data_o,
  output logic               head_valid_o,
  output logic               head_done_o,
  output ooo_pkg::arch_reg_t head_rd_o,
  output logic [TAG_W-1:0]   head_tag_o,
  output ooo_pkg::word_t     head_data_o
);

  logic [TAG_W-1:0]   head_q;
  logic [TAG_W-1:0]   tail_q;
  logic [TAG_W:0]     count_q;
  logic [DEPTH-1:0]   done_q;
  ooo_pkg::arch_reg_t rd_q [DEPTH];
  ooo_pkg::word_t     data_q [DEPTH];

  function automatic logic [TAG_W-1:0] ptr_inc(input logic [TAG_W-1:0] ptr);
    if (ptr == TAG_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      done_q  <= '0;
    end else begin
      if (alloc_i) begin
        tail_q         <= ptr_inc(tail_q);
        done_q[tail_q] <= 1'b0;
      end
      if (cdb_valid_i) begin
        done_q[cdb_tag_i] <= 1'b1;
      end
      if (retire_i) begin
        head_q <= ptr_inc(head_q);
      end
      if (alloc_i && !retire_i) begin
        count_q <= count_q + 1'b1;
      end else if (!alloc_i && retire_i) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (alloc_i) begin
      rd_q[tail_q] <= alloc_rd_i;
    end
    if (cdb_valid_i) begin
      data_q[cdb_tag_i] <= cdb_data_i;
    end
  end

  assign alloc_tag_o = tail_q;

  // results done but not yet retired
  assign src0_done_o = done_q[src0_tag_i];
  assign src0_data_o = data_q[src0_tag_i];
  assign src1_done_o = done_q[src1_tag_i];
  assign src1_data_o = data_q[src1_tag_i];

  assign head_valid_o = (count_q != '0);
  assign head_done_o  = done_q[head_q];
  assign head_rd_o    = rd_q[head_q];
  assign head_tag_o   = head_q;
  assign head_data_o  = data_q[head_q];

endmodule

// ==== rtl/alu_issue_queue.sv ====
`timescale 1ns/10ps

module alu_issue_queue #(
  parameter int DEPTH = 8,
  localparam int TAG_W = $clog2(DEPTH),
  localparam int IDX_W = $clog2(DEPTH)
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             disp_valid_i,
  input  ooo_pkg::alu_op_e disp_op_i,
  input  logic [TAG_W-1:0] disp_tag_i,
  input  logic             disp_src0_rdy_i,
  input  logic [TAG_W-1:0] disp_src0_tag_i,
  input  ooo_pkg::word_t   disp_src0_val_i,
  input  logic             disp_src1_rdy_i,
  input  logic [TAG_W-1:0] disp_src1_tag_i,
  input  ooo_pkg::word_t   disp_src1_val_i,
  input  logic             cdb_valid_i,
  input  logic [TAG_W-1:0] cdb_tag_i,
  input  ooo_pkg::word_t   cdb_data_i,
  output logic             cdb_valid_o,
  output logic [TAG_W-1:0] cdb_tag_o,
  output ooo_pkg::word_t   cdb_data_o
);

  logic [DEPTH-1:0] valid_q;
  // bit j set when slot j holds an older instruction than slot i
  logic [DEPTH-1:0] age_q [DEPTH];
  logic [1:0]       rdy_q [DEPTH];
  logic [TAG_W-1:0] stag_q [DEPTH][2];
  ooo_pkg::word_t   sval_q [DEPTH][2];
  ooo_pkg::alu_op_e op_q [DEPTH];
  logic [TAG_W-1:0] dtag_q [DEPTH];

  logic [DEPTH-1:0] ready;
  logic [DEPTH-1:0] grant;
  logic             issue;
  logic [IDX_W-1:0] issue_idx;
  logic [IDX_W-1:0] free_idx;
  logic [1:0]       disp_rdy;
  logic [TAG_W-1:0] disp_tag [2];
  ooo_pkg::word_t   disp_val [2];
  ooo_pkg::word_t   res;

  function automatic ooo_pkg::word_t alu_eval(input ooo_pkg::alu_op_e op,
                                              input ooo_pkg::word_t a,
                                              input ooo_pkg::word_t b);
    case (op)
      ooo_pkg::op_add: return a + b;
      ooo_pkg::op_sub: return a - b;
      ooo_pkg::op_and: return a & b;
      ooo_pkg::op_or:  return a | b;
      ooo_pkg::op_xor: return a ^ b;
      ooo_pkg::op_sll: return a << b[4:0];
      ooo_pkg::op_srl: return a >> b[4:0];
      ooo_pkg::op_slt: return {31'b0, $signed(a) < $signed(b)};
      default:         return a + b;
    endcase
  endfunction

  // oldest ready entry wins
  always_comb begin
    for (int i = 0; i < DEPTH; i++) begin
      ready[i] = valid_q[i] && (&rdy_q[i]);
    end
    for (int i = 0; i < DEPTH; i++) begin
      grant[i] = ready[i] && !(|(age_q[i] & ready));
    end
    issue     = |grant;
    issue_idx = '0;
    free_idx  = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (grant[i]) begin
        issue_idx = IDX_W'(i);
      end
      if (!valid_q[i]) begin
        free_idx = IDX_W'(i);
      end
    end
  end

  // catch a broadcast that lands in the dispatch cycle
  always_comb begin
    disp_rdy[0] = disp_src0_rdy_i;
    disp_tag[0] = disp_src0_tag_i;
    disp_val[0] = disp_src0_val_i;
    disp_rdy[1] = disp_src1_rdy_i;
    disp_tag[1] = disp_src1_tag_i;
    disp_val[1] = disp_src1_val_i;
    for (int s = 0; s < 2; s++) begin
      if (!disp_rdy[s] && cdb_valid_i && (cdb_tag_i == disp_tag[s])) begin
        disp_rdy[s] = 1'b1;
        disp_val[s] = cdb_data_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
      for (int i = 0; i < DEPTH; i++) begin
        age_q[i] <= '0;
      end
    end else begin
      if (issue) begin
        valid_q[issue_idx] <= 1'b0;
      end
      if (disp_valid_i) begin
        valid_q[free_idx] <= 1'b1;
        age_q[free_idx]   <= valid_q;
        for (int i = 0; i < DEPTH; i++) begin
          age_q[i][free_idx] <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < DEPTH; i++) begin
      for (int s = 0; s < 2; s++) begin
        if (cdb_valid_i && !rdy_q[i][s] && (stag_q[i][s] == cdb_tag_i)) begin
          rdy_q[i][s]  <= 1'b1;
          sval_q[i][s] <= cdb_data_i;
        end
      end
    end
    if (disp_valid_i) begin
      op_q[free_idx]   <= disp_op_i;
      dtag_q[free_idx] <= disp_tag_i;
      for (int s = 0; s < 2; s++) begin
        rdy_q[free_idx][s]  <= disp_rdy[s];
        stag_q[free_idx][s] <= disp_tag[s];
        sval_q[free_idx][s] <= disp_val[s];
      end
    end
  end

  assign res = alu_eval(op_q[issue_idx], sval_q[issue_idx][0], sval_q[issue_idx][1]);

  // registered ALU stage drives the CDB
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cdb_valid_o <= 1'b0;
    end else begin
      cdb_valid_o <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      cdb_tag_o  <= dtag_q[issue_idx];
      cdb_data_o <= res;
    end
  end

endmodule

// ==== rtl/commit_ctrl.sv ====
`timescale 1ns/10ps

module commit_ctrl #(
  parameter int DEPTH = 8,
  localparam int TAG_W = $clog2(DEPTH)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               head_valid_i,
  input  logic               head_done_i,
  input  ooo_pkg::arch_reg_t head_rd_i,
  input  logic [TAG_W-1:0]   head_tag_i,
  input  ooo_pkg::word_t     head_data_i,
  input  logic               alloc_i,
  input  ooo_pkg::arch_reg_t alloc_rd_i,
  output logic               retire_o,
  output logic               rf_we_o,
  output ooo_pkg::arch_reg_t rf_waddr_o,
  output ooo_pkg::word_t     rf_wdata_o,
  output logic               clear_o,
  output ooo_pkg::arch_reg_t clear_rd_o,
  output logic [TAG_W-1:0]   clear_tag_o,
  output logic               credit_o,
  output logic               retire_valid_o,
  output ooo_pkg::arch_reg_t retire_rd_o,
  output ooo_pkg::word_t     retire_data_o
);

  ooo_pkg::commit_state_e state_q;
  ooo_pkg::commit_state_e state_d;
  logic                   rd_collide;

  assign retire_o   = (state_q == ooo_pkg::st_run) && head_valid_i && head_done_i;
  assign rd_collide = alloc_i && (alloc_rd_i == head_rd_i);

  assign rf_we_o    = retire_o && (head_rd_i != '0);
  assign rf_waddr_o = head_rd_i;
  assign rf_wdata_o = head_data_i;

  // new mapping to the same rd wins over the release
  assign clear_o     = rf_we_o && !rd_collide;
  assign clear_rd_o  = head_rd_i;
  assign clear_tag_o = head_tag_i;

  assign credit_o       = retire_o;
  assign retire_valid_o = retire_o;
  assign retire_rd_o    = head_rd_i;
  assign retire_data_o  = head_data_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ooo_pkg::st_run: begin
        if (retire_o && ((head_rd_i == '0) || rd_collide)) begin
          state_d = ooo_pkg::st_drain;
        end
      end
      ooo_pkg::st_drain: begin
        state_d = ooo_pkg::st_run;
      end
      default: begin
        state_d = ooo_pkg::st_run;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= ooo_pkg::st_run;
    end else begin
      state_q <= state_d;
    end
  end

endmodule

// ==== rtl/ooo_backend.sv ====
`timescale 1ns/10ps

module ooo_backend #(
  parameter int DEPTH = 8,
  localparam int TAG_W = $clog2(DEPTH)
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               inst_valid_i,
  input  ooo_pkg::alu_op_e   inst_op_i,
  input  ooo_pkg::arch_reg_t inst_rd_i,
  input  ooo_pkg::arch_reg_t inst_rs1_i,
  input  ooo_pkg::arch_reg_t inst_rs2_i,
  input  logic               inst_use_imm_i,
  input  ooo_pkg::word_t     inst_imm_i,
  output logic               credit_o,
  output logic               retire_valid_o,
  output ooo_pkg::arch_reg_t retire_rd_o,
  output ooo_pkg::word_t     retire_data_o
);

  logic               rs1_busy;
  logic               rs2_busy;
  logic [TAG_W-1:0]   rs1_tag;
  logic [TAG_W-1:0]   rs2_tag;
  ooo_pkg::word_t     rf_rdata0;
  ooo_pkg::word_t     rf_rdata1;
  logic               rf_we;
  ooo_pkg::arch_reg_t rf_waddr;
  ooo_pkg::word_t     rf_wdata;
  logic [TAG_W-1:0]   alloc_tag;
  logic               src0_done;
  logic               src1_done;
  ooo_pkg::word_t     src0_data;
  ooo_pkg::word_t     src1_data;
  logic               head_valid;
  logic               head_done;
  ooo_pkg::arch_reg_t head_rd;
  logic [TAG_W-1:0]   head_tag;
  ooo_pkg::word_t     head_data;
  logic               retire;
  logic               clear;
  ooo_pkg::arch_reg_t clear_rd;
  logic [TAG_W-1:0]   clear_tag;
  logic               cdb_valid;
  logic [TAG_W-1:0]   cdb_tag;
  ooo_pkg::word_t     cdb_data;
  logic               op0_rdy;
  logic               op1_rdy;
  ooo_pkg::word_t     op0_val;
  ooo_pkg::word_t     op1_val;

  // unmapped sources read the register file, mapped ones the ROB
  always_comb begin
    op0_rdy = !rs1_busy || src0_done;
    op0_val = rs1_busy ? src0_data : rf_rdata0;
    if (inst_use_imm_i) begin
      op1_rdy = 1'b1;
      op1_val = inst_imm_i;
    end else begin
      op1_rdy = !rs2_busy || src1_done;
      op1_val = rs2_busy ? src1_data : rf_rdata1;
    end
  end

  rename_table #(.DEPTH(DEPTH)) u_rename (
    .clk(clk), .rst_n(rst_n),
    .rs1_i(inst_rs1_i), .rs2_i(inst_rs2_i),
    .alloc_i(inst_valid_i), .alloc_rd_i(inst_rd_i), .alloc_tag_i(alloc_tag),
    .clear_i(clear), .clear_rd_i(clear_rd), .clear_tag_i(clear_tag),
    .rs1_busy_o(rs1_busy), .rs1_tag_o(rs1_tag),
    .rs2_busy_o(rs2_busy), .rs2_tag_o(rs2_tag)
  );

  arch_regfile u_regfile (
    .clk(clk), .rst_n(rst_n),
    .raddr0_i(inst_rs1_i), .raddr1_i(inst_rs2_i),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata),
    .rdata0_o(rf_rdata0), .rdata1_o(rf_rdata1)
  );

  reorder_buffer #(.DEPTH(DEPTH)) u_rob (
    .clk(clk), .rst_n(rst_n),
    .alloc_i(inst_valid_i), .alloc_rd_i(inst_rd_i),
    .cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag), .cdb_data_i(cdb_data),
    .src0_tag_i(rs1_tag), .src1_tag_i(rs2_tag),
    .retire_i(retire),
    .alloc_tag_o(alloc_tag),
    .src0_done_o(src0_done), .src0_data_o(src0_data),
    .src1_done_o(src1_done), .src1_data_o(src1_data),
    .head_valid_o(head_valid), .head_done_o(head_done),
    .head_rd_o(head_rd), .head_tag_o(head_tag), .head_data_o(head_data)
  );

  alu_issue_queue #(.DEPTH(DEPTH)) u_iq (
    .clk(clk), .rst_n(rst_n),
    .disp_valid_i(inst_valid_i), .disp_op_i(inst_op_i), .disp_tag_i(alloc_tag),
    .disp_src0_rdy_i(op0_rdy), .disp_src0_tag_i(rs1_tag), .disp_src0_val_i(op0_val),
    .disp_src1_rdy_i(op1_rdy), .disp_src1_tag_i(rs2_tag), .disp_src1_val_i(op1_val),
    .cdb_valid_i(cdb_valid), .cdb_tag_i(cdb_tag), .cdb_data_i(cdb_data),
    .cdb_valid_o(cdb_valid), .cdb_tag_o(cdb_tag), .cdb_data_o(cdb_data)
  );

  commit_ctrl #(.DEPTH(DEPTH)) u_commit (
    .clk(clk), .rst_n(rst_n),
    .head_valid_i(head_valid), .head_done_i(head_done),
    .head_rd_i(head_rd), .head_tag_i(head_tag), .head_data_i(head_data),
    .alloc_i(inst_valid_i), .alloc_rd_i(inst_rd_i),
    .retire_o(retire),
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .clear_o(clear), .clear_rd_o(clear_rd), .clear_tag_o(clear_tag),
    .credit_o(credit_o),
    .retire_valid_o(retire_valid_o), .retire_rd_o(retire_rd_o),
    .retire_data_o(retire_data_o)
  );

endmodule

// ==== dv/tb_ooo_backend.sv ====
`timescale 1ns/10ps

module tb_ooo_backend;

  localparam int DEPTH = 8;

  logic               clk;
  logic               rst_n;
  logic               inst_valid_i;
  ooo_pkg::alu_op_e   inst_op_i;
  ooo_pkg::arch_reg_t inst_rd_i;
  ooo_pkg::arch_reg_t inst_rs1_i;
  ooo_pkg::arch_reg_t inst_rs2_i;
  logic               inst_use_imm_i;
  ooo_pkg::word_t     inst_imm_i;
  logic               credit_o;
  logic               retire_valid_o;
  ooo_pkg::arch_reg_t retire_rd_o;
  ooo_pkg::word_t     retire_data_o;

  logic [31:0] gold_regs [32];
  logic [4:0]  exp_rd [$];
  logic [31:0] exp_val [$];
  int          credits;
  int          credit_pulses;
  int          retire_count;
  int          sent_count;
  int          cycle_count;
  int unsigned seed_init;

  ooo_backend #(.DEPTH(DEPTH)) DUT (
    .clk(clk), .rst_n(rst_n),
    .inst_valid_i(inst_valid_i), .inst_op_i(inst_op_i),
    .inst_rd_i(inst_rd_i), .inst_rs1_i(inst_rs1_i), .inst_rs2_i(inst_rs2_i),
    .inst_use_imm_i(inst_use_imm_i), .inst_imm_i(inst_imm_i),
    .credit_o(credit_o), .retire_valid_o(retire_valid_o),
    .retire_rd_o(retire_rd_o), .retire_data_o(retire_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic end_in_failure();
    $display("STATUS: FAIL");
    $fatal(1, "run stopped at first failure");
  endtask

  task automatic value_error(input string what, input logic [31:0] expected,
                             input logic [31:0] got);
    $display("error at %0t ns: %s, expected %0h got %0h", $time, what, expected, got);
    end_in_failure();
  endtask

  // in-order reference for one ALU operation
  function automatic logic [31:0] golden_result(input ooo_pkg::alu_op_e op,
                                                input logic [31:0] a,
                                                input logic [31:0] b);
    case (op)
      ooo_pkg::op_add: return a + b;
      ooo_pkg::op_sub: return a - b;
      ooo_pkg::op_and: return a & b;
      ooo_pkg::op_or:  return a | b;
      ooo_pkg::op_xor: return a ^ b;
      ooo_pkg::op_sll: return a << b[4:0];
      ooo_pkg::op_srl: return a >> b[4:0];
      default:         return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    endcase
  endfunction

  // one instruction per call, only while a credit is held
  task automatic send_inst(input ooo_pkg::alu_op_e op, input int rd, input int rs1,
                           input int rs2, input bit use_imm, input logic [31:0] imm);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    while (credits == 0) @(negedge clk);
    a   = gold_regs[rs1];
    b   = use_imm ? imm : gold_regs[rs2];
    res = golden_result(op, a, b);
    if (rd != 0) gold_regs[rd] = res;
    exp_rd.push_back(rd[4:0]);
    exp_val.push_back(res);
    inst_valid_i   = 1'b1;
    inst_op_i      = op;
    inst_rd_i      = ooo_pkg::arch_reg_t'(rd);
    inst_rs1_i     = ooo_pkg::arch_reg_t'(rs1);
    inst_rs2_i     = ooo_pkg::arch_reg_t'(rs2);
    inst_use_imm_i = use_imm;
    inst_imm_i     = imm;
    credits--;
    sent_count++;
    @(negedge clk);
    inst_valid_i = 1'b0;
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clk);
  endtask

  task automatic drain();
    while (exp_rd.size() != 0) @(negedge clk);
    assert (credits == DEPTH)
      else value_error("credits after drain", DEPTH, credits);
  endtask

  // retire monitor and credit bookkeeping
  always @(posedge clk) begin
    if (rst_n) begin
      if (credit_o) begin
        assert (credits < DEPTH)
          else value_error("credit counter above depth", DEPTH, credits + 1);
        credits++;
        credit_pulses++;
      end
      if (retire_valid_o) begin
        retire_count++;
        if (exp_rd.size() == 0) begin
          $display("retire seen with no instruction outstanding at %0t ns", $time);
          end_in_failure();
        end
        assert (retire_rd_o == exp_rd[0])
          else value_error("retire rd", exp_rd[0], retire_rd_o);
        assert (retire_data_o == exp_val[0])
          else value_error("retire data", exp_val[0], retire_data_o);
        void'(exp_rd.pop_front());
        void'(exp_val.pop_front());
      end
    end
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count > 20 * sent_count + 200) begin
      $display("timeout: the backend stopped retiring within the cycle limit");
      end_in_failure();
    end
  end

  task automatic independent_ops_test();
    for (int i = 1; i <= 8; i++) begin
      send_inst(ooo_pkg::op_add, i, 0, 0, 1'b1, $urandom);
    end
    for (int i = 0; i < 8; i++) begin
      send_inst(ooo_pkg::alu_op_e'(i), 9 + i, 1 + i, 8 - i, 1'b0, '0);
    end
    drain();
  endtask

  task automatic dependency_chain_test();
    int prev;
    int rd;
    prev = 20;
    send_inst(ooo_pkg::op_add, 20, 0, 0, 1'b1, 32'h1234_5678);
    // back to back, so each source waits on the CDB
    for (int k = 0; k < 10; k++) begin
      rd = 21 + (k % 3);
      send_inst(ooo_pkg::alu_op_e'(k % 8), rd, prev, prev, k[0], k + 3);
      prev = rd;
    end
    idle(3);
    send_inst(ooo_pkg::op_add, 24, prev, 20, 1'b0, '0);
    drain();
    // sources now come from the register file
    send_inst(ooo_pkg::op_sub, 25, 24, prev, 1'b0, '0);
    send_inst(ooo_pkg::op_xor, 26, 25, 21, 1'b0, '0);
    drain();
  endtask

  task automatic credit_flow_test();
    int c0;
    int r0;
    c0 = credit_pulses;
    r0 = retire_count;
    for (int i = 0; i < 8; i++) begin
      send_inst(ooo_pkg::op_or, 10 + i, 10 + i, 0, 1'b1, 32'h100 << i);
    end
    // each returned credit must come with its own retire
    while (credit_pulses - c0 < 8) @(negedge clk);
    assert (retire_count - r0 == 8)
      else value_error("retires when eight credits came back", 8, retire_count - r0);
    drain();
  endtask

  task automatic zero_reg_test();
    send_inst(ooo_pkg::op_add, 0, 1, 2, 1'b0, '0);
    send_inst(ooo_pkg::op_or, 0, 0, 0, 1'b1, 32'hdead_beef);
    send_inst(ooo_pkg::op_add, 5, 0, 0, 1'b0, '0);
    send_inst(ooo_pkg::op_xor, 6, 0, 3, 1'b0, '0);
    drain();
  endtask

  task automatic rename_overwrite_test();
    send_inst(ooo_pkg::op_add, 7, 0, 0, 1'b1, 32'h11);
    send_inst(ooo_pkg::op_add, 7, 0, 0, 1'b1, 32'h22);
    send_inst(ooo_pkg::op_add, 7, 7, 0, 1'b1, 32'h33);
    // older writes retire while the newest is still in flight
    idle(2);
    send_inst(ooo_pkg::op_add, 8, 7, 7, 1'b0, '0);
    drain();
    send_inst(ooo_pkg::op_add, 9, 7, 0, 1'b1, '0);
    drain();
  endtask

  task automatic random_mix_test();
    for (int n = 0; n < 200; n++) begin
      send_inst(ooo_pkg::alu_op_e'($urandom_range(7, 0)), $urandom_range(31, 0),
                $urandom_range(31, 0), $urandom_range(31, 0),
                bit'($urandom_range(1, 0)), $urandom);
      if ($urandom_range(3, 0) == 0) idle($urandom_range(3, 1));
    end
    drain();
  endtask

  initial begin
    seed_init      = $urandom(17);
    rst_n          = 1'b0;
    inst_valid_i   = 1'b0;
    inst_op_i      = ooo_pkg::op_add;
    inst_rd_i      = '0;
    inst_rs1_i     = '0;
    inst_rs2_i     = '0;
    inst_use_imm_i = 1'b0;
    inst_imm_i     = '0;
    credits        = DEPTH;
    credit_pulses  = 0;
    retire_count   = 0;
    sent_count     = 0;
    cycle_count    = 0;
    for (int i = 0; i < 32; i++) begin
      gold_regs[i] = '0;
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    idle(2);
    independent_ops_test();
    dependency_chain_test();
    credit_flow_test();
    zero_reg_test();
    rename_overwrite_test();
    random_mix_test();
    $display("STATUS: PASS");
    $finish;
  end

endmodule

// ==== build.f ====
rtl/ooo_pkg.sv
rtl/rename_table.sv
rtl/arch_regfile.sv
rtl/reorder_buffer.sv
rtl/alu_issue_queue.sv
rtl/commit_ctrl.sv
rtl/ooo_backend.sv
dv/tb_ooo_backend.sv

// ==== Bender.yml ====
package:
  name: ooo_backend

sources:
  - rtl/ooo_pkg.sv
  - rtl/rename_table.sv
  - rtl/arch_regfile.sv
  - rtl/reorder_buffer.sv
  - rtl/alu_issue_queue.sv
  - rtl/commit_ctrl.sv
  - rtl/ooo_backend.sv
  - target: test
    files:
      - dv/tb_ooo_backend.sv
